//--- project.f
+incdir+.
arcade_pkg.sv
rom_loader.sv
rom_store.sv
rotary_encoder.sv
input_mapper.sv
arcade_core_top.sv
tb_clock.sv
arcade_checker.sv
arcade_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= arcade_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- arcade_tb.sv
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module arcade_tb;
	import arcade_pkg::*;

	localparam int WAW = `ROM_ADDR_BITS - 1;
	localparam int AW = `ROM_ADDR_BITS;
	localparam int N_BYTES = 256;
	localparam int TABLE_LEN = 7;
	localparam int ROT_WINDOW = 4 * (1 << `ROTARY_DIV_BITS);
	// download and three rotary windows plus slack for reset, readback and table
	localparam int TIMEOUT_CYCLES = TABLE_LEN + N_BYTES * (`STORE_WAIT + 4) +
		3 * ROT_WINDOW + 2048;

	typedef struct packed {
		logic [31:0] status;
		joy_t        joy0;
		joy_t        joy1;
		sys_btn_t    sys_btn;
		logic [1:0]  is_bootleg;
		player_t     p1;
		player_t     p2;
		logic [1:0]  coins_n;
		logic [1:0]  starts_n;
		logic        service_n;
		logic [23:0] dip_sw;
	} map_case_t;

	logic           clock_49;
	logic           rst_n;
	ioctl_t         ioctl;
	logic [31:0]    status;
	joy_t           joy0;
	joy_t           joy1;
	sys_btn_t       sys_btn;
	logic [1:0]     is_bootleg;
	logic [WAW-1:0] rd_addr;
	logic           dl_ready;
	logic           core_reset_n;
	player_t        p1;
	player_t        p2;
	logic [1:0]     coins_n;
	logic [1:0]     starts_n;
	logic           service_n;
	logic [23:0]    dip_sw;
	logic [7:0]     p1_rotary;
	logic [7:0]     p2_rotary;
	logic [15:0]    rd_data;

	map_case_t   cases [TABLE_LEN];
	logic [7:0]  model [N_BYTES];
	logic [31:0] rnd;
	logic [7:0]  p1_hold;
	logic [7:0]  p2_hold;
	logic        left_wrap = 1'b0;
	logic        right_wrap = 1'b0;
	integer      seed = 22051;
	int          value_errors = 0;
	int          other_errors = 0;
	int          stall_cycles = 0;
	int          cycle_cnt = 0;

	tb_clock #(.PERIOD_NS(8)) u_clock (.clock_49(clock_49));

	arcade_core_top UUT (
		.clock_49     (clock_49),
		.rst_n        (rst_n),
		.ioctl        (ioctl),
		.status       (status),
		.joy0         (joy0),
		.joy1         (joy1),
		.sys_btn      (sys_btn),
		.is_bootleg   (is_bootleg),
		.rd_addr      (rd_addr),
		.dl_ready     (dl_ready),
		.core_reset_n (core_reset_n),
		.p1           (p1),
		.p2           (p2),
		.coins_n      (coins_n),
		.starts_n     (starts_n),
		.service_n    (service_n),
		.dip_sw       (dip_sw),
		.p1_rotary    (p1_rotary),
		.p2_rotary    (p2_rotary),
		.rd_data      (rd_data)
	);

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		value_errors++;
		$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic other_error(input string msg);
		other_errors++;
		$display("** Failure at %0t ns: %s", $time, msg);
	endtask

	task automatic finish_run();
		$display("checks done: %0d value errors, %0d other errors",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	// inputs change and outputs are read 1 ns after the edge
	task automatic next_cycle();
		@(posedge clock_49);
		#1;
	endtask

	task automatic wait_reset_level(input logic level, input string what);
		int guard;
		guard = 0;
		while (core_reset_n !== level && guard < 8) begin
			next_cycle();
			guard++;
		end
		if (core_reset_n !== level)
			other_error(what);
	endtask

	// rotate turns directions clockwise and joyswap feeds joy1 to player 1
	task automatic load_table();
		cases[0] = '{32'h0000_0000, 8'h00, 8'h00, 4'b0000, 2'b00,
			6'h3F, 6'h3F, 2'b11, 2'b11, 1'b1, 24'hFFFFFF};
		cases[1] = '{32'h0000_0000, 8'h01, 8'h08, 4'b1000, 2'b00,
			6'h3E, 6'h37, 2'b10, 2'b11, 1'b1, 24'hFFFFFF};
		cases[2] = '{32'h0000_0004, 8'h01, 8'h02, 4'b0010, 2'b00,
			6'h37, 6'h3B, 2'b11, 2'b10, 1'b1, 24'hFFFFFF};
		cases[3] = '{32'h0000_0040, 8'h10, 8'h24, 4'b0100, 2'b00,
			6'h1B, 6'h2F, 2'b01, 2'b11, 1'b1, 24'hFFFFFF};
		cases[4] = '{32'hA5C3_0080, 8'h0F, 8'h00, 4'b0001, 2'b10,
			6'h30, 6'h3F, 2'b11, 2'b01, 1'b0, 24'h5A3CFF};
		cases[5] = '{32'h1234_5644, 8'h08, 8'h31, 4'b1111, 2'b00,
			6'h07, 6'h3D, 2'b00, 2'b00, 1'b1, 24'hEDCBA9};
		cases[6] = '{32'h0000_0001, 8'hC0, 8'h0A, 4'b0000, 2'b00,
			6'h3F, 6'h35, 2'b11, 2'b11, 1'b1, 24'hFFFFFF};
	endtask

	// source pulses a byte whenever dl_ready is seen high
	task automatic run_download();
		int i;
		int guard;
		i = 0;
		guard = 0;
		ioctl.downloading = 1'b1;
		next_cycle();
		while (i < N_BYTES) begin
			if (core_reset_n !== 1'b0)
				value_error("core_reset_n", 32'(core_reset_n), 32'h0);
			if (dl_ready) begin
				ioctl.wr = 1'b1;
				ioctl.addr = AW'(i);
				ioctl.dout = model[i];
				i++;
			end else begin
				// a second low cycle in a row means the loader ran out of credits
				if (!ioctl.wr)
					stall_cycles++;
				ioctl.wr = 1'b0;
			end
			next_cycle();
		end
		ioctl.wr = 1'b0;
		while (dl_ready !== 1'b1 && guard < 64) begin
			next_cycle();
			guard++;
		end
		if (dl_ready !== 1'b1)
			other_error("dl_ready stayed low after the last byte");
		if (stall_cycles == 0)
			other_error("dl_ready never stayed low for lack of credits");
		ioctl.downloading = 1'b0;
	endtask

	task automatic read_back();
		int w;
		int guard;
		logic [15:0] exp;
		guard = 0;
		// every credit home means every word reached the RAM
		while (UUT.u_rom_loader.credit_cnt != `ROM_CREDITS && guard < 64) begin
			next_cycle();
			guard++;
		end
		if (UUT.u_rom_loader.credit_cnt != `ROM_CREDITS)
			other_error("store never returned all credits");
		for (w = 0; w < N_BYTES / 2; w++) begin
			rd_addr = WAW'(w);
			next_cycle();
			next_cycle();
			exp = {model[2 * w + 1], model[2 * w]};
			if (rd_data !== exp)
				value_error($sformatf("rd_data[%0d]", w), 32'(rd_data), 32'(exp));
		end
	endtask

	task automatic apply_table();
		int r;
		for (r = 0; r < TABLE_LEN; r++) begin
			status = cases[r].status;
			joy0 = cases[r].joy0;
			joy1 = cases[r].joy1;
			sys_btn = cases[r].sys_btn;
			is_bootleg = cases[r].is_bootleg;
			next_cycle();
			if (p1 !== cases[r].p1)
				value_error("p1", 32'(p1), 32'(cases[r].p1));
			if (p2 !== cases[r].p2)
				value_error("p2", 32'(p2), 32'(cases[r].p2));
			if (coins_n !== cases[r].coins_n)
				value_error("coins_n", 32'(coins_n), 32'(cases[r].coins_n));
			if (starts_n !== cases[r].starts_n)
				value_error("starts_n", 32'(starts_n), 32'(cases[r].starts_n));
			if (service_n !== cases[r].service_n)
				value_error("service_n", 32'(service_n), 32'(cases[r].service_n));
			if (dip_sw !== cases[r].dip_sw)
				value_error("dip_sw", 32'(dip_sw), 32'(cases[r].dip_sw));
		end
	endtask

	// every change of p1_rotary must be one step in the held direction
	task automatic rotary_window(input logic left, input int min_steps,
		input int max_steps, input string label);
		logic [7:0] prev;
		logic [7:0] exp;
		int steps;
		int c;
		prev = p1_rotary;
		steps = 0;
		for (c = 0; c < ROT_WINDOW; c++) begin
			next_cycle();
			if (p1_rotary !== prev) begin
				exp = left ? {prev[6:0], prev[7]} : {prev[0], prev[7:1]};
				if (p1_rotary !== exp)
					value_error("p1_rotary", 32'(p1_rotary), 32'(exp));
				if (left && prev == 8'h80 && p1_rotary == 8'h01)
					left_wrap = 1'b1;
				if (!left && prev == 8'h01 && p1_rotary == 8'h80)
					right_wrap = 1'b1;
				steps++;
				prev = p1_rotary;
			end
		end
		if (steps < min_steps || steps > max_steps)
			other_error($sformatf("%s: p1_rotary stepped %0d times, expected %0d to %0d",
				label, steps, min_steps, max_steps));
	endtask

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clock_49);
			cycle_cnt++;
		end
		other_error($sformatf("timeout after %0d cycles, tests did not complete", cycle_cnt));
		finish_run();
	end

	initial begin
		rst_n = 1'b0;
		ioctl = '0;
		status = '0;
		joy0 = '0;
		joy1 = '0;
		sys_btn = '0;
		is_bootleg = 2'b00;
		rd_addr = '0;
		load_table();
		for (int i = 0; i < N_BYTES; i++) begin
			rnd = $random(seed);
			model[i] = rnd[7:0];
		end
		repeat (8) @(posedge clock_49);
		#1;
		rst_n = 1'b1;

		if (core_reset_n !== 1'b0)
			value_error("core_reset_n", 32'(core_reset_n), 32'h0);
		if (dl_ready !== 1'b1)
			value_error("dl_ready", 32'(dl_ready), 32'h1);
		if (p1_rotary !== 8'h01)
			value_error("p1_rotary", 32'(p1_rotary), 32'h01);
		if (p2_rotary !== 8'h01)
			value_error("p2_rotary", 32'(p2_rotary), 32'h01);

		run_download();
		wait_reset_level(1'b1, "core_reset_n did not rise after downloading fell");
		status = 32'h0000_0001;
		wait_reset_level(1'b0, "core_reset_n stayed high with status bit 0 set");
		status = '0;
		wait_reset_level(1'b1, "core_reset_n stayed low after status bit 0 cleared");

		read_back();
		apply_table();

		// fire_c steps the p1 ring left and fire_d steps it right
		status = '0;
		joy0 = 8'h40;
		joy1 = '0;
		sys_btn = '0;
		is_bootleg = 2'b00;
		p2_hold = p2_rotary;
		rotary_window(1'b1, 3, 4, "normal left");
		status = 32'h0000_0002;
		rotary_window(1'b1, 7, 8, "fast left");
		joy0 = 8'h80;
		rotary_window(1'b0, 7, 8, "fast right");
		if (!left_wrap)
			other_error("p1_rotary never wrapped from 80 to 01 stepping left");
		if (!right_wrap)
			other_error("p1_rotary never wrapped from 01 to 80 stepping right");
		if (p2_rotary !== p2_hold)
			value_error("p2_rotary", 32'(p2_rotary), 32'(p2_hold));

		// bootleg override keeps the rings in place underneath
		joy0 = '0;
		next_cycle();
		p1_hold = p1_rotary;
		p2_hold = p2_rotary;
		is_bootleg = 2'b01;
		repeat (16) begin
			next_cycle();
			if (p1_rotary !== 8'hFF)
				value_error("p1_rotary", 32'(p1_rotary), 32'hFF);
			if (p2_rotary !== 8'hFF)
				value_error("p2_rotary", 32'(p2_rotary), 32'hFF);
		end
		is_bootleg = 2'b00;
		next_cycle();
		if (p1_rotary !== p1_hold)
			value_error("p1_rotary", 32'(p1_rotary), 32'(p1_hold));
		if (p2_rotary !== p2_hold)
			value_error("p2_rotary", 32'(p2_rotary), 32'(p2_hold));

		finish_run();
	end

endmodule

//--- arcade_checker.sv
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module arcade_checker (
	input logic                                 clock_49,
	input logic                                 rst_n,
	input arcade_pkg::loader_state_e            state,
	input logic [$clog2(`ROM_CREDITS + 1)-1:0] credit_cnt,
	input logic                                 wr_valid,
	input logic                                 credit_ret,
	input logic                                 dl_ready
);
	import arcade_pkg::*;

	logic [$clog2(`ROM_CREDITS + 1)-1:0] in_flight;

	// words handed to the store whose credit has not come back yet
	always_ff @(posedge clock_49 or negedge rst_n) begin
		if (!rst_n)
			in_flight <= '0;
		else if (wr_valid && !credit_ret)
			in_flight <= in_flight + 1'b1;
		else if (credit_ret && !wr_valid)
			in_flight <= in_flight - 1'b1;
	end

	credit_limit: assert property (@(posedge clock_49) disable iff (!rst_n)
		credit_cnt <= `ROM_CREDITS)
		else $error("loader credit count %0d above the FIFO depth", credit_cnt);

	// words in flight never outnumber the FIFO entries
	write_needs_credit: assert property (@(posedge clock_49) disable iff (!rst_n)
		wr_valid |-> in_flight < `ROM_CREDITS)
		else $error("word write issued with no credit left");

	// a held word keeps the source blocked until it is sent
	hold_blocks_source: assert property (@(posedge clock_49) disable iff (!rst_n)
		state == LD_HOLD && !wr_valid |=> state == LD_HOLD && !dl_ready)
		else $error("loader released the source before its word was sent");

endmodule

bind rom_loader arcade_checker u_arcade_checker (
	.clock_49   (clock_49),
	.rst_n      (rst_n),
	.state      (state),
	.credit_cnt (credit_cnt),
	.wr_valid   (wr.valid),
	.credit_ret (credit_ret),
	.dl_ready   (dl_ready)
);

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 8
) (
	output logic clock_49
);
	initial clock_49 = 1'b0;

	always #(PERIOD_NS / 2) clock_49 = ~clock_49;

endmodule

//--- arcade_core_top.sv
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module arcade_core_top (
	input  logic                      clock_49,
	input  logic                      rst_n,
	input  arcade_pkg::ioctl_t        ioctl,
	input  logic [31:0]               status,
	input  arcade_pkg::joy_t          joy0,
	input  arcade_pkg::joy_t          joy1,
	input  arcade_pkg::sys_btn_t      sys_btn,
	input  logic [1:0]                is_bootleg,
	input  logic [`ROM_ADDR_BITS-2:0] rd_addr,
	output logic                      dl_ready,
	output logic                      core_reset_n,
	output arcade_pkg::player_t       p1,
	output arcade_pkg::player_t       p2,
	output logic [1:0]                coins_n,
	output logic [1:0]                starts_n,
	output logic                      service_n,
	output logic [23:0]               dip_sw,
	output logic [7:0]                p1_rotary,
	output logic [7:0]                p2_rotary,
	output logic [15:0]               rd_data
);
	import arcade_pkg::*;

	core_cfg_t cfg;
	rom_wr_t   rom_wr;
	logic      credit_ret;
	rot_dir_e  p1_dir;
	rot_dir_e  p2_dir;

	assign dip_sw = cfg.dip_sw;

	input_mapper u_input_mapper (
		.status    (status),
		.joy0      (joy0),
		.joy1      (joy1),
		.sys_btn   (sys_btn),
		.cfg       (cfg),
		.p1        (p1),
		.p2        (p2),
		.coins_n   (coins_n),
		.starts_n  (starts_n),
		.service_n (service_n),
		.p1_dir    (p1_dir),
		.p2_dir    (p2_dir)
	);

	rom_loader u_rom_loader (
		.clock_49     (clock_49),
		.rst_n        (rst_n),
		.ioctl        (ioctl),
		.status_reset (cfg.core_reset),
		.credit_ret   (credit_ret),
		.wr           (rom_wr),
		.dl_ready     (dl_ready),
		.core_reset_n (core_reset_n)
	);

	rom_store u_rom_store (
		.clock_49   (clock_49),
		.rst_n      (rst_n),
		.wr         (rom_wr),
		.rd_addr    (rd_addr),
		.credit_ret (credit_ret),
		.rd_data    (rd_data)
	);

	rotary_encoder u_rotary_encoder (
		.clock_49   (clock_49),
		.rst_n      (rst_n),
		.fast       (cfg.rotary_fast),
		.is_bootleg (is_bootleg),
		.p1_dir     (p1_dir),
		.p2_dir     (p2_dir),
		.p1_rotary  (p1_rotary),
		.p2_rotary  (p2_rotary)
	);

endmodule

//--- input_mapper.sv
`timescale 1ns/1ps

module input_mapper (
	input  logic [31:0]           status,
	input  arcade_pkg::joy_t      joy0,
	input  arcade_pkg::joy_t      joy1,
	input  arcade_pkg::sys_btn_t  sys_btn,
	output arcade_pkg::core_cfg_t cfg,
	output arcade_pkg::player_t   p1,
	output arcade_pkg::player_t   p2,
	output logic [1:0]            coins_n,
	output logic [1:0]            starts_n,
	output logic                  service_n,
	output arcade_pkg::rot_dir_e  p1_dir,
	output arcade_pkg::rot_dir_e  p2_dir
);
	import arcade_pkg::*;

	joy_t j1;
	joy_t j2;

	// rotate turns the stick a quarter clockwise for the vertical screen
	function automatic player_t map_player(input joy_t j, input logic rot);
		player_t p;
		if (rot) begin
			p.up = ~j.right;
			p.right = ~j.down;
			p.down = ~j.left;
			p.left = ~j.up;
		end else begin
			p.up = ~j.up;
			p.right = ~j.right;
			p.down = ~j.down;
			p.left = ~j.left;
		end
		p.fire_a = ~j.fire_a;
		p.fire_b = ~j.fire_b;
		return p;
	endfunction

	// fire_c has priority over fire_d
	function automatic rot_dir_e map_dir(input joy_t j);
		if (j.fire_c)
			return ROT_LEFT;
		else if (j.fire_d)
			return ROT_RIGHT;
		return ROT_NONE;
	endfunction

	assign cfg.core_reset = status[0];
	assign cfg.rotary_fast = status[1];
	assign cfg.rotate = status[2];
	assign cfg.joyswap = status[6];
	assign cfg.service = status[7];
	assign cfg.dip_sw = ~status[31:8];

	assign j1 = cfg.joyswap ? joy1 : joy0;
	assign j2 = cfg.joyswap ? joy0 : joy1;

	assign p1 = map_player(j1, cfg.rotate);
	assign p2 = map_player(j2, cfg.rotate);
	assign p1_dir = map_dir(j1);
	assign p2_dir = map_dir(j2);

	assign coins_n = ~{sys_btn.coin2, sys_btn.coin1};
	assign starts_n = ~{sys_btn.start2, sys_btn.start1};
	assign service_n = ~cfg.service;

endmodule

//--- rotary_encoder.sv
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module rotary_encoder (
	input  logic                 clock_49,
	input  logic                 rst_n,
	input  logic                 fast,
	input  logic [1:0]           is_bootleg,
	input  arcade_pkg::rot_dir_e p1_dir,
	input  arcade_pkg::rot_dir_e p2_dir,
	output logic [7:0]           p1_rotary,
	output logic [7:0]           p2_rotary
);
	import arcade_pkg::*;

	logic [`ROTARY_DIV_BITS-1:0] div_cnt;
	logic                        tick;
	logic                        bootleg;
	logic [7:0]                  ring1;
	logic [7:0]                  ring2;

	// one-hot ring, rotation wraps 80 <-> 01 by itself
	function automatic logic [7:0] step_ring(input logic [7:0] ring, input rot_dir_e dir);
		case (dir)
			ROT_LEFT:  step_ring = {ring[6:0], ring[7]};
			ROT_RIGHT: step_ring = {ring[0], ring[7:1]};
			default:   step_ring = ring;
		endcase
	endfunction

	// fast mode ignores the top divider bit, doubling the rate
	assign tick = (div_cnt == '0) ||
		(fast && div_cnt[`ROTARY_DIV_BITS-2:0] == '0);

	always_ff @(posedge clock_49 or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock_49 or negedge rst_n) begin
		if (!rst_n) begin
			ring1 <= 8'h01;
			ring2 <= 8'h01;
		end else if (tick) begin
			ring1 <= step_ring(ring1, p1_dir);
			ring2 <= step_ring(ring2, p2_dir);
		end
	end

	// bootleg boards have no rotary hardware, rings keep their position
	assign bootleg = (is_bootleg == 2'b01);
	assign p1_rotary = bootleg ? 8'hFF : ring1;
	assign p2_rotary = bootleg ? 8'hFF : ring2;

endmodule

//--- rom_store.sv
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module rom_store (
	input  logic                      clock_49,
	input  logic                      rst_n,
	input  arcade_pkg::rom_wr_t       wr,
	input  logic [`ROM_ADDR_BITS-2:0] rd_addr,
	output logic                      credit_ret,
	output logic [15:0]               rd_data
);
	localparam int DEPTH = `ROM_CREDITS;
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);
	localparam int WAIT_BITS = $clog2(`STORE_WAIT + 1);
	localparam int WORDS = 1 << (`ROM_ADDR_BITS - 1);

	logic [`ROM_ADDR_BITS-2:0] fifo_addr [DEPTH];
	logic [15:0]               fifo_data [DEPTH];
	logic [PTR_BITS-1:0]       wr_ptr;
	logic [PTR_BITS-1:0]       rd_ptr;
	logic [CNT_BITS-1:0]       fifo_cnt;
	logic [WAIT_BITS-1:0]      wait_cnt;
	logic [15:0]               ram [WORDS];
	logic [`ROM_ADDR_BITS-2:0] rd_addr_q;
	logic                      pop;

	// head entry drains after STORE_WAIT cycles like a slow SDRAM port
	assign pop = (fifo_cnt != '0) && (wait_cnt == WAIT_BITS'(`STORE_WAIT));
	assign credit_ret = pop;

	always_ff @(posedge clock_49 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			wait_cnt <= '0;
		end else begin
			if (wr.valid)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			if (wr.valid && !pop)
				fifo_cnt <= fifo_cnt + 1'b1;
			else if (pop && !wr.valid)
				fifo_cnt <= fifo_cnt - 1'b1;

			if (pop || fifo_cnt == '0)
				wait_cnt <= '0;
			else
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// words enter at the tail and leave from the head into the RAM
	always_ff @(posedge clock_49) begin
		if (wr.valid) begin
			fifo_addr[wr_ptr] <= wr.addr;
			fifo_data[wr_ptr] <= wr.data;
		end
		if (pop)
			ram[fifo_addr[rd_ptr]] <= fifo_data[rd_ptr];
	end

	// cpu rom port registers the address and then the data
	always_ff @(posedge clock_49) begin
		rd_addr_q <= rd_addr;
		rd_data <= ram[rd_addr_q];
	end

endmodule

//--- rom_loader.sv
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module rom_loader (
	input  logic                clock_49,
	input  logic                rst_n,
	input  arcade_pkg::ioctl_t  ioctl,
	input  logic                status_reset,
	input  logic                credit_ret,
	output arcade_pkg::rom_wr_t wr,
	output logic                dl_ready,
	output logic                core_reset_n
);
	import arcade_pkg::*;

	localparam int CREDIT_BITS = $clog2(`ROM_CREDITS + 1);

	loader_state_e             state;
	logic [CREDIT_BITS-1:0]    credit_cnt;
	logic [7:0]                lo_byte;
	logic [7:0]                hi_byte;
	logic [`ROM_ADDR_BITS-2:0] word_addr;
	logic                      downloading_d;
	logic                      rom_loaded;
	logic                      byte_wr;
	logic                      send;

	assign byte_wr = ioctl.downloading & ioctl.wr;
	// a word leaves as soon as one credit is free
	assign send = (state == LD_HOLD) && (credit_cnt != '0);
	assign dl_ready = (state != LD_HOLD);

	assign wr.valid = send;
	assign wr.addr = word_addr;
	assign wr.data = {hi_byte, lo_byte};

	always_ff @(posedge clock_49 or negedge rst_n) begin
		if (!rst_n) begin
			state <= LD_WAIT_LOW;
		end else begin
			case (state)
				LD_WAIT_LOW: begin
					if (byte_wr && !ioctl.addr[0])
						state <= LD_WAIT_HIGH;
				end
				LD_WAIT_HIGH: begin
					// even byte again restarts the pair
					if (byte_wr && ioctl.addr[0])
						state <= LD_HOLD;
				end
				default: begin
					if (send)
						state <= LD_WAIT_LOW;
				end
			endcase
		end
	end

	always_ff @(posedge clock_49) begin
		if (byte_wr && state != LD_HOLD) begin
			if (!ioctl.addr[0]) begin
				lo_byte <= ioctl.dout;
			end else begin
				hi_byte <= ioctl.dout;
				word_addr <= ioctl.addr[`ROM_ADDR_BITS-1:1];
			end
		end
	end

	always_ff @(posedge clock_49 or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= CREDIT_BITS'(`ROM_CREDITS);
		end else if (send && !credit_ret) begin
			credit_cnt <= credit_cnt - 1'b1;
		end else if (credit_ret && !send) begin
			credit_cnt <= credit_cnt + 1'b1;
		end
	end

	// end of download arms the core, menu reset holds it
	always_ff @(posedge clock_49 or negedge rst_n) begin
		if (!rst_n) begin
			downloading_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset_n <= 1'b0;
		end else begin
			downloading_d <= ioctl.downloading;
			if (downloading_d && !ioctl.downloading)
				rom_loaded <= 1'b1;
			core_reset_n <= ~(status_reset | ~rom_loaded);
		end
	end

endmodule

//--- arcade_pkg.sv
`include "arcade_cfg.svh"

package arcade_pkg;

	// decoded download stream, one byte per wr pulse
	typedef struct packed {
		logic                      downloading;
		logic                      wr;
		logic [`ROM_ADDR_BITS-1:0] addr;
		logic [7:0]                dout;
	} ioctl_t;

	// one 16-bit word write towards the ROM store
	typedef struct packed {
		logic                      valid;
		logic [`ROM_ADDR_BITS-2:0] addr;
		logic [15:0]               data;
	} rom_wr_t;

	// user_io joystick byte, bit 0 is right, active high
	typedef struct packed {
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
	} sys_btn_t;

	// controls as the game core sees them, active low
	typedef struct packed {
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	typedef struct packed {
		logic        core_reset;
		logic        rotary_fast;
		logic        rotate;
		logic        joyswap;
		logic        service;
		logic [23:0] dip_sw;
	} core_cfg_t;

	typedef enum logic [1:0] {
		LD_WAIT_LOW,
		LD_WAIT_HIGH,
		LD_HOLD
	} loader_state_e;

	typedef enum logic [1:0] {
		ROT_NONE,
		ROT_LEFT,
		ROT_RIGHT
	} rot_dir_e;

endpackage

//--- arcade_cfg.svh
`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// byte address width of the ROM download, word address is one bit narrower
`define ROM_ADDR_BITS 12

// store FIFO depth and loader starting credits
`define ROM_CREDITS 4

// cycles an entry sits at the FIFO head before the RAM write
`define STORE_WAIT 3

// rotary step divider width, normal tick every 2**N cycles
`define ROTARY_DIV_BITS 10

`endif
